/* logic/demux_bus_pkg.sv */
//####################################################################
// Core-side bus definitions for the data demux
// Bus widths, request payload and response payload
//####################################################################

package demux_bus_pkg;

  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;
  parameter int BE_W   = DATA_W / 8;

  // Request payload, the valid and grant levels travel beside it
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              wen;    // High for loads, low for stores
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } req_t;

  // Response payload, valid is a one-cycle pulse
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
    logic              err;    // Error/opcode flag from the target
  } rsp_t;

endpackage

/* logic/demux_map_pkg.sv */
//####################################################################
// Cluster memory map for the data demux
// Target enumeration, one-hot vector type, region slot offsets,
// remap nibble and stall counter width
//####################################################################

package demux_map_pkg;

  parameter int N_TGT = 3;

  // Target index, also the bit position in tgt_vec_t
  typedef enum logic [1:0] {
    SH  = 2'd0,  // Shared TCDM
    PE  = 2'd1,  // Peripheral interconnect
    EXT = 2'd2   // Demux peripherals
  } tgt_e;

  typedef logic [N_TGT-1:0] tgt_vec_t;

  // Address bits 31:20, one 1 MiB slot
  typedef logic [11:0] region_t;
  // Top address nibble
  typedef logic [3:0]  nibble_t;

  parameter region_t     CLUSTER_BASE  = 12'h100;
  parameter int unsigned REGION_STRIDE = 4;      // Slots per cluster

  parameter int unsigned OFS_TCDM_RW = 0;
  parameter int unsigned OFS_TCDM_TS = 1;        // Test-and-set alias of TCDM
  parameter int unsigned OFS_PERIPH  = 2;

  parameter int      DEMUX_SEL_BIT = 14;         // EXT inside the periph slot
  parameter nibble_t REMAP_NIBBLE  = 4'h1;

  parameter int CNT_W = 32;

endpackage

/* logic/addr_decode.sv */
//####################################################################
// Address decoder of the core demux
// Optional top-nibble remap against base_addr_i, cluster region
// from cluster_id_i, optional alias region, one-hot target select
//####################################################################

`timescale 1ns/100ps

module addr_decode #(
  parameter bit                     CLUSTER_ALIAS = 1'b1,
  parameter demux_map_pkg::region_t ALIAS_BASE    = 12'h000,
  parameter bit                     REMAP_ADDRESS = 1'b0
) (
  input  demux_bus_pkg::req_t     core_req_i,
  input  logic [3:0]              base_addr_i,
  input  logic [5:0]              cluster_id_i,
  output demux_bus_pkg::req_t     req_o,
  output demux_map_pkg::tgt_vec_t tgt_sel_o
);

  import demux_bus_pkg::*;
  import demux_map_pkg::*;

  nibble_t nib_in;
  nibble_t nib_out;
  region_t cl_base;
  region_t region;
  logic    hit_tcdm;
  logic    hit_periph;

  // True when region r is slot ofs above base
  function automatic logic slot_hit(region_t r, region_t base, int unsigned ofs);
    return r == region_t'(base + ofs);
  endfunction

  assign nib_in = core_req_i.addr[ADDR_W-1 -: 4];

  if (REMAP_ADDRESS) begin : g_remap
    // Swap base_addr_i and REMAP_NIBBLE, leave the rest alone
    always_comb begin
      if (nib_in == base_addr_i) begin
        nib_out = REMAP_NIBBLE;
      end else if (nib_in == REMAP_NIBBLE) begin
        nib_out = base_addr_i;
      end else begin
        nib_out = nib_in;
      end
    end
  end else begin : g_no_remap
    assign nib_out = nib_in;
  end

  always_comb begin
    req_o                     = core_req_i;
    req_o.addr[ADDR_W-1 -: 4] = nib_out;
  end

  assign cl_base = region_t'(CLUSTER_BASE + REGION_STRIDE * cluster_id_i);
  assign region  = req_o.addr[ADDR_W-1 -: 12];

  // Both TCDM slots go to SH
  assign hit_tcdm = slot_hit(region, cl_base, OFS_TCDM_RW)
                  | slot_hit(region, cl_base, OFS_TCDM_TS)
                  | (CLUSTER_ALIAS & (slot_hit(region, ALIAS_BASE, OFS_TCDM_RW)
                                    | slot_hit(region, ALIAS_BASE, OFS_TCDM_TS)));

  assign hit_periph = slot_hit(region, cl_base, OFS_PERIPH)
                    | (CLUSTER_ALIAS & slot_hit(region, ALIAS_BASE, OFS_PERIPH));

  // Exactly one bit set, PE catches everything outside the cluster
  always_comb begin
    tgt_sel_o = '0;
    if (hit_tcdm) begin
      tgt_sel_o[SH] = 1'b1;
    end else if (hit_periph && req_o.addr[DEMUX_SEL_BIT]) begin
      tgt_sel_o[EXT] = 1'b1;
    end else begin
      tgt_sel_o[PE] = 1'b1;
    end
  end

endmodule

/* logic/target_port.sv */
//####################################################################
// One target port of the core demux
// Request gating, RSP_STAGES response pipeline and stall counter
//####################################################################

`timescale 1ns/100ps

module target_port #(
  parameter int RSP_STAGES = 0
) (
  input  logic                            clk,
  input  logic                            rst_ni,
  input  logic                            req_valid_i,
  input  logic                            sel_i,
  input  demux_bus_pkg::req_t             req_i,
  input  logic                            stall_clr_i,
  output logic                            tgt_req_valid_o,
  output demux_bus_pkg::req_t             tgt_req_o,
  input  logic                            tgt_gnt_i,
  input  demux_bus_pkg::rsp_t             tgt_rsp_i,
  output demux_bus_pkg::rsp_t             rsp_o,
  output logic [demux_map_pkg::CNT_W-1:0] stall_cnt_o
);

  import demux_bus_pkg::*;
  import demux_map_pkg::*;

  logic [CNT_W-1:0] stall_cnt_q;

  assign tgt_req_valid_o = req_valid_i & sel_i;
  assign tgt_req_o       = req_i;  // Payload is shared, only valid is gated

  if (RSP_STAGES == 0) begin : g_bypass
    assign rsp_o = tgt_rsp_i;
  end else begin : g_pipe
    logic [RSP_STAGES-1:0] vld_q;
    logic [RSP_STAGES-1:0] err_q;
    logic [DATA_W-1:0]     rdata_q [RSP_STAGES];

    always_ff @(posedge clk or negedge rst_ni) begin
      if (!rst_ni) begin
        vld_q <= '0;
      end else begin
        vld_q[0] <= tgt_rsp_i.valid;
        for (int i = 1; i < RSP_STAGES; i++) begin
          vld_q[i] <= vld_q[i-1];
        end
      end
    end

    // Data moves only with its valid, so stages keep distinct responses
    always_ff @(posedge clk) begin
      if (tgt_rsp_i.valid) begin
        rdata_q[0] <= tgt_rsp_i.rdata;
        err_q[0]   <= tgt_rsp_i.err;
      end
      for (int i = 1; i < RSP_STAGES; i++) begin
        if (vld_q[i-1]) begin
          rdata_q[i] <= rdata_q[i-1];
          err_q[i]   <= err_q[i-1];
        end
      end
    end

    always_comb begin
      rsp_o.valid = vld_q[RSP_STAGES-1];
      rsp_o.rdata = rdata_q[RSP_STAGES-1];
      rsp_o.err   = err_q[RSP_STAGES-1];
    end
  end

  // Cycles where the request waits on a low grant
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_cnt_q <= '0;
    end else if (stall_clr_i) begin
      stall_cnt_q <= '0;
    end else if (tgt_req_valid_o && !tgt_gnt_i) begin
      stall_cnt_q <= stall_cnt_q + CNT_W'(1);
    end
  end

  assign stall_cnt_o = stall_cnt_q;

endmodule

/* logic/return_mux.sv */
//####################################################################
// Return path of the core demux
// Grant select, destination register, response select and
// L2 performance strobes
//####################################################################

`timescale 1ns/100ps

module return_mux (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  logic                    req_valid_i,
  input  logic                    req_wen_i,
  input  demux_map_pkg::tgt_vec_t tgt_sel_i,
  input  demux_map_pkg::tgt_vec_t tgt_gnt_i,
  input  demux_bus_pkg::rsp_t     rsp_i [demux_map_pkg::N_TGT],
  output logic                    core_gnt_o,
  output demux_bus_pkg::rsp_t     core_rsp_o,
  output logic                    perf_l2_ld_o,
  output logic                    perf_l2_st_o,
  output logic                    perf_l2_ld_cyc_o,
  output logic                    perf_l2_st_cyc_o
);

  import demux_map_pkg::*;

  tgt_e dest_d;
  tgt_e dest_q;
  logic l2_req;

  // Grant of whichever target the decoder picks this cycle
  assign core_gnt_o = |(tgt_sel_i & tgt_gnt_i);

  // One-hot to index
  always_comb begin
    dest_d = SH;
    if (tgt_sel_i[PE]) begin
      dest_d = PE;
    end else if (tgt_sel_i[EXT]) begin
      dest_d = EXT;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      dest_q <= SH;
    end else if (req_valid_i) begin
      dest_q <= dest_d;  // Updated on every request, granted or not
    end
  end

  always_comb begin
    case (dest_q)
      SH: begin
        core_rsp_o     = rsp_i[SH];
        core_rsp_o.err = 1'b0;   // TCDM never reports errors
      end
      PE:      core_rsp_o = rsp_i[PE];
      EXT:     core_rsp_o = rsp_i[EXT];
      default: core_rsp_o = '0;
    endcase
  end

  // Anything leaving the cluster TCDM counts as L2 traffic
  assign l2_req = req_valid_i & (tgt_sel_i[PE] | tgt_sel_i[EXT]);

  assign perf_l2_ld_o     = l2_req & core_gnt_o & req_wen_i;
  assign perf_l2_st_o     = l2_req & core_gnt_o & ~req_wen_i;
  assign perf_l2_ld_cyc_o = l2_req & req_wen_i;
  assign perf_l2_st_cyc_o = l2_req & ~req_wen_i;

endmodule

/* logic/core_demux.sv */
//####################################################################
// Core-side data demux, top level
// Address decoder, one target port per target, return mux
//####################################################################

`timescale 1ns/100ps

module core_demux #(
  parameter bit                     CLUSTER_ALIAS = 1'b1,
  parameter demux_map_pkg::region_t ALIAS_BASE    = 12'h000,
  parameter bit                     REMAP_ADDRESS = 1'b0,
  parameter int                     PE_RSP_STAGES = 2
) (
  input  logic                            clk,
  input  logic                            rst_ni,
  input  logic [3:0]                      base_addr_i,
  input  logic [5:0]                      cluster_id_i,

  input  logic                            core_req_valid_i,
  input  demux_bus_pkg::req_t             core_req_i,
  output logic                            core_gnt_o,
  output demux_bus_pkg::rsp_t             core_rsp_o,

  output demux_map_pkg::tgt_vec_t         tgt_req_valid_o,
  output demux_bus_pkg::req_t             tgt_req_o [demux_map_pkg::N_TGT],
  input  demux_map_pkg::tgt_vec_t         tgt_gnt_i,
  input  demux_bus_pkg::rsp_t             tgt_rsp_i [demux_map_pkg::N_TGT],

  input  logic                            stall_clr_i,
  output logic [demux_map_pkg::CNT_W-1:0] stall_cnt_o [demux_map_pkg::N_TGT],

  output logic                            perf_l2_ld_o,
  output logic                            perf_l2_st_o,
  output logic                            perf_l2_ld_cyc_o,
  output logic                            perf_l2_st_cyc_o
);

  import demux_bus_pkg::*;
  import demux_map_pkg::*;

  req_t     dec_req;
  tgt_vec_t tgt_sel;
  rsp_t     port_rsp [N_TGT];  // Responses after each port's stages

  addr_decode #(
    .CLUSTER_ALIAS ( CLUSTER_ALIAS ),
    .ALIAS_BASE    ( ALIAS_BASE    ),
    .REMAP_ADDRESS ( REMAP_ADDRESS )
  ) i_addr_decode (
    .core_req_i   ( core_req_i   ),
    .base_addr_i  ( base_addr_i  ),
    .cluster_id_i ( cluster_id_i ),
    .req_o        ( dec_req      ),
    .tgt_sel_o    ( tgt_sel      )
  );

  // Index k follows tgt_e, only PE gets response stages
  for (genvar k = 0; k < N_TGT; k++) begin : g_tgt
    target_port #(
      .RSP_STAGES ( (k == int'(PE)) ? PE_RSP_STAGES : 0 )
    ) i_target_port (
      .clk             ( clk                ),
      .rst_ni          ( rst_ni             ),
      .req_valid_i     ( core_req_valid_i   ),
      .sel_i           ( tgt_sel[k]         ),
      .req_i           ( dec_req            ),
      .stall_clr_i     ( stall_clr_i        ),
      .tgt_req_valid_o ( tgt_req_valid_o[k] ),
      .tgt_req_o       ( tgt_req_o[k]       ),
      .tgt_gnt_i       ( tgt_gnt_i[k]       ),
      .tgt_rsp_i       ( tgt_rsp_i[k]       ),
      .rsp_o           ( port_rsp[k]        ),
      .stall_cnt_o     ( stall_cnt_o[k]     )
    );
  end

  return_mux i_return_mux (
    .clk              ( clk              ),
    .rst_ni           ( rst_ni           ),
    .req_valid_i      ( core_req_valid_i ),
    .req_wen_i        ( dec_req.wen      ),
    .tgt_sel_i        ( tgt_sel          ),
    .tgt_gnt_i        ( tgt_gnt_i        ),
    .rsp_i            ( port_rsp         ),
    .core_gnt_o       ( core_gnt_o       ),
    .core_rsp_o       ( core_rsp_o       ),
    .perf_l2_ld_o     ( perf_l2_ld_o     ),
    .perf_l2_st_o     ( perf_l2_st_o     ),
    .perf_l2_ld_cyc_o ( perf_l2_ld_cyc_o ),
    .perf_l2_st_cyc_o ( perf_l2_st_cyc_o )
  );

endmodule

/* sim/core_demux_chk.sv */
//####################################################################
// Bound checker for the core demux return path
// At most one target request per cycle, grant follows the decoded
// destination
//####################################################################

`timescale 1ns/100ps

module core_demux_chk (
  input logic                    clk,
  input logic                    rst_ni,
  input logic                    req_valid_i,
  input demux_map_pkg::tgt_vec_t tgt_sel_i,
  input demux_map_pkg::tgt_vec_t tgt_gnt_i,
  input demux_map_pkg::tgt_e     dest_i,
  input logic                    core_gnt_o
);

  import demux_map_pkg::*;

  tgt_vec_t req_vec;

  assign req_vec = tgt_sel_i & {N_TGT{req_valid_i}};  // Requests seen by the targets

  a_one_req: assert property (@(posedge clk) disable iff (!rst_ni)
    $onehot0(req_vec))
    else $error("More than one target request valid in one cycle");

  // Grant must come from the target the return path records
  a_gnt_src: assert property (@(posedge clk) disable iff (!rst_ni)
    core_gnt_o |-> tgt_gnt_i[dest_i])
    else $error("Core grant without grant from the selected target");

endmodule

bind return_mux core_demux_chk u_chk (
  .clk         ( clk         ),
  .rst_ni      ( rst_ni      ),
  .req_valid_i ( req_valid_i ),
  .tgt_sel_i   ( tgt_sel_i   ),
  .tgt_gnt_i   ( tgt_gnt_i   ),
  .dest_i      ( dest_d      ),
  .core_gnt_o  ( core_gnt_o  )
);

/* sim/core_demux_tb.sv */
//####################################################################
// Testbench for the core demux
// Clock, reset, target models, xorshift stimulus,
// reference decoder and response comparison
//####################################################################

`timescale 1ns/100ps

module core_demux_tb;

  import demux_bus_pkg::*;
  import demux_map_pkg::*;

  localparam logic [3:0] BASE_NIB = 4'h5;
  localparam logic [5:0] CL_ID    = 6'd3;  // Cluster region starts at 0x10C

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } exp_t;

  logic        clk = 1'b0;
  logic        rst_ni;
  logic [3:0]  base_addr;
  logic [5:0]  cluster_id;
  logic        req_valid;
  req_t        req;
  logic        core_gnt;
  rsp_t        core_rsp;
  tgt_vec_t    tgt_req_valid;
  req_t        tgt_req [N_TGT];
  tgt_vec_t    tgt_gnt;
  rsp_t        tgt_rsp [N_TGT];
  logic        stall_clr;
  logic [31:0] stall_cnt [N_TGT];
  logic [3:0]  perf;                     // ld, st, ld_cyc, st_cyc

  exp_t        exp_q [$];
  int          due_q [$];                // Cycle where each response is due
  int          cyc = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          withheld [N_TGT];
  logic [31:0] rng = 32'h9b03d104;

  always #10 clk = ~clk;

  core_demux #(
    .CLUSTER_ALIAS ( 1'b1    ),
    .ALIAS_BASE    ( 12'h000 ),
    .REMAP_ADDRESS ( 1'b1    ),
    .PE_RSP_STAGES ( 2       )
  ) dut (
    .clk              ( clk           ),
    .rst_ni           ( rst_ni        ),
    .base_addr_i      ( base_addr     ),
    .cluster_id_i     ( cluster_id    ),
    .core_req_valid_i ( req_valid     ),
    .core_req_i       ( req           ),
    .core_gnt_o       ( core_gnt      ),
    .core_rsp_o       ( core_rsp      ),
    .tgt_req_valid_o  ( tgt_req_valid ),
    .tgt_req_o        ( tgt_req       ),
    .tgt_gnt_i        ( tgt_gnt       ),
    .tgt_rsp_i        ( tgt_rsp       ),
    .stall_clr_i      ( stall_clr     ),
    .stall_cnt_o      ( stall_cnt     ),
    .perf_l2_ld_o     ( perf[3]       ),
    .perf_l2_st_o     ( perf[2]       ),
    .perf_l2_ld_cyc_o ( perf[1]       ),
    .perf_l2_st_cyc_o ( perf[0]       )
  );

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] model_key(int k);
    case (k)
      0:       return 32'ha5a5_0000;
      1:       return 32'h5a5a_1111;
      default: return 32'h3c3c_2222;
    endcase
  endfunction

  // Exchange base nibble and nibble 1 (the swap is its own inverse)
  function automatic logic [31:0] swap_nibble(logic [31:0] a, logic [3:0] base);
    logic [31:0] r;
    r = a;
    if (a[31:28] == base) begin
      r[31:28] = 4'h1;
    end else if (a[31:28] == 4'h1) begin
      r[31:28] = base;
    end
    return r;
  endfunction

  // Expected target index and forwarded address
  function automatic void ref_decode(input logic [31:0] addr, input logic [3:0] base,
                                     input logic [5:0] cid, input bit alias_en,
                                     input logic [11:0] alias_base, input bit remap_en,
                                     output int tgt, output logic [31:0] fwd);
    logic [11:0] cl;
    logic [11:0] rgn;
    logic        in_tcdm;
    logic        in_periph;
    fwd = remap_en ? swap_nibble(addr, base) : addr;
    cl  = 12'h100 + 12'(cid) * 12'd4;
    rgn = fwd[31:20];
    in_tcdm = (rgn == cl) || (rgn == cl + 12'd1) ||
              (alias_en && (rgn == alias_base || rgn == alias_base + 12'd1));
    in_periph = (rgn == cl + 12'd2) || (alias_en && rgn == alias_base + 12'd2);
    if (in_tcdm) begin
      tgt = 0;
    end else if (in_periph && fwd[14]) begin
      tgt = 2;
    end else begin
      tgt = 1;
    end
  endfunction

  task automatic report_value(string name, logic [31:0] got, logic [31:0] expv);
    $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expv);
    errors++;
  endtask

  // Target models answer one cycle after each granted request
  always @(posedge clk) begin
    rsp_t nxt [N_TGT];
    for (int k = 0; k < N_TGT; k++) begin
      nxt[k] = '0;
      if (tgt_req_valid[k] && tgt_gnt[k]) begin
        nxt[k].valid = 1'b1;
        nxt[k].rdata = tgt_req[k].addr ^ model_key(k);
        nxt[k].err   = tgt_req[k].addr[2];               // Every model flags odd words
        due_q.push_back(cyc + ((k == 1) ? 3 : 1));       // PE adds two stages
      end
    end
    #2;
    for (int k = 0; k < N_TGT; k++) begin
      tgt_rsp[k] = nxt[k];
    end
  end

  // Response comparison at the falling edge
  always @(negedge clk) begin
    exp_t e;
    int   due;
    cyc++;
    if (core_rsp.valid) begin
      if (exp_q.size() == 0 || due_q.size() == 0) begin
        $display("Response arrived with no request outstanding");
        errors++;
      end else begin
        e   = exp_q.pop_front();
        due = due_q.pop_front();
        if (due != cyc) begin
          $display("Response arrived in cycle %0d, expected in cycle %0d", cyc, due);
          errors++;
        end
        if (core_rsp.rdata !== e.rdata) report_value("core_rsp_o.rdata", core_rsp.rdata, e.rdata);
        if (core_rsp.err !== e.err) report_value("core_rsp_o.err", core_rsp.err, e.err);
      end
    end else if (due_q.size() > 0 && due_q[0] < cyc) begin
      $display("Response due in cycle %0d never arrived", due_q[0]);
      errors++;
      void'(due_q.pop_front());
      if (exp_q.size() > 0) void'(exp_q.pop_front());
    end
  end

  task automatic check_fwd(int t, logic [31:0] fwd, logic wen);
    tgt_vec_t   exp_v;
    logic       l2;
    logic [3:0] exp_perf;
    exp_v    = tgt_vec_t'(1) << t;
    l2       = (t != 0);
    exp_perf = {l2 & wen & tgt_gnt[t], l2 & ~wen & tgt_gnt[t], l2 & wen, l2 & ~wen};
    if (tgt_req_valid !== exp_v) report_value("tgt_req_valid_o", tgt_req_valid, exp_v);
    if (tgt_req[t].addr !== fwd) report_value("tgt_req_o.addr", tgt_req[t].addr, fwd);
    if (core_gnt !== tgt_gnt[t]) report_value("core_gnt_o", core_gnt, tgt_gnt[t]);
    if (perf !== exp_perf) report_value("perf_l2 {ld,st,ld_cyc,st_cyc}", perf, exp_perf);
  endtask

  // One request with the grant held low for hold cycles
  task automatic do_req(logic [31:0] addr, logic wen, int hold);
    int          t;
    int          waited;
    logic [31:0] fwd;
    logic        granted;
    exp_t        e;
    ref_decode(addr, BASE_NIB, CL_ID, 1'b1, 12'h000, 1'b1, t, fwd);
    req.addr  = addr;
    req.wen   = wen;
    req.wdata = next_rand();
    req.be    = 4'hf;
    req_valid = 1'b1;
    tgt_gnt[t] = (hold == 0);
    waited  = 0;
    granted = 1'b0;
    while (!granted && waited <= hold + 20) begin
      @(negedge clk);
      check_fwd(t, fwd, wen);
      granted = tgt_gnt[t];
      if (granted) begin
        e.rdata = fwd ^ model_key(t);
        e.err   = (t != 0) && fwd[2];  // SH never reports an error
        exp_q.push_back(e);
      end else begin
        withheld[t]++;
      end
      @(posedge clk);
      #2;
      waited++;
      if (waited >= hold) tgt_gnt[t] = 1'b1;
    end
    req_valid = 1'b0;
    if (!granted) begin
      $display("Request to 0x%08h was never granted", addr);
      errors++;
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((exp_q.size() > 0 || due_q.size() > 0) && n < 40) begin
      @(negedge clk);
      n++;
    end
    if (n >= 40) begin
      $display("Responses still outstanding after 40 cycles");
      errors++;
      exp_q.delete();
      due_q.delete();
    end
    @(posedge clk);
    #2;
  endtask

  task automatic pulse_clear();
    stall_clr = 1'b1;
    @(posedge clk);
    #2;
    stall_clr = 1'b0;
  endtask

  task automatic end_test(int num, string name, int err_before);
    tests_run++;
    if (errors > err_before) tests_failed++;
    $display("Test %0d %s: %s", num, name, (errors > err_before) ? "FAILED" : "ok");
  endtask

  // Target-side address in one of the interesting regions
  function automatic logic [31:0] pick_addr();
    logic [31:0] r;
    r = next_rand();
    case (r[31:29])
      3'd0:    return {12'h10c, r[19:0]};
      3'd1:    return {12'h10d, r[19:0]};
      3'd2:    return {12'h10e, r[19:15], 1'b0, r[13:0]};
      3'd3:    return {12'h10e, r[19:15], 1'b1, r[13:0]};
      3'd4:    return {10'h0, (r[21:20] == 2'd3) ? 2'd2 : r[21:20], r[19:0]};
      default: return next_rand();
    endcase
  endfunction

  initial begin
    int          e0;
    logic [31:0] a;
    logic [31:0] r;
    rst_ni     = 1'b0;
    base_addr  = BASE_NIB;
    cluster_id = CL_ID;
    req_valid  = 1'b0;
    req        = '0;
    tgt_gnt    = '1;
    stall_clr  = 1'b0;
    for (int k = 0; k < N_TGT; k++) begin
      tgt_rsp[k]  = '0;
      withheld[k] = 0;
    end
    repeat (8) @(posedge clk);
    #2;
    rst_ni = 1'b1;

    e0 = errors;
    @(negedge clk);
    if (tgt_req_valid !== '0) report_value("tgt_req_valid_o", tgt_req_valid, 0);
    if (core_rsp.valid !== 1'b0) report_value("core_rsp_o.valid", core_rsp.valid, 0);
    for (int k = 0; k < N_TGT; k++) begin
      if (stall_cnt[k] !== '0) report_value("stall_cnt_o", stall_cnt[k], 0);
    end
    @(posedge clk);
    #2;
    end_test(1, "reset state", e0);

    e0 = errors;
    repeat (60) begin
      r = next_rand();
      do_req(swap_nibble(pick_addr(), BASE_NIB), r[0], 0);
      drain();
    end
    end_test(2, "address decode", e0);

    e0 = errors;
    repeat (24) begin
      a = next_rand();
      if (a[1:0] == 2'd0) a[31:28] = BASE_NIB;
      else if (a[1:0] == 2'd1) a[31:28] = 4'h1;
      do_req(a, 1'b1, 0);
      drain();
    end
    end_test(3, "nibble remap", e0);

    e0 = errors;
    do_req(32'h50c0_0104, 1'b1, 0);
    drain();
    do_req(32'h50e0_4004, 1'b1, 0);
    drain();
    do_req(32'h2000_0010, 1'b1, 0);
    drain();
    for (int i = 0; i < 4; i++) begin
      do_req(32'h2000_0100 + 32'(4 * i), 1'b1, 0);  // Back to back with odd and even words
    end
    drain();
    end_test(4, "response path", e0);

    e0 = errors;
    pulse_clear();
    for (int k = 0; k < N_TGT; k++) withheld[k] = 0;
    repeat (12) begin
      r = next_rand();
      a = (r[1:0] == 2'd0) ? 32'h50c0_0000 : (r[1:0] == 2'd1) ? 32'h50e0_4000 : 32'h3000_0000;
      do_req(a, r[8], int'(r[31:16] % 6) + 1);
      drain();
    end
    @(negedge clk);
    for (int k = 0; k < N_TGT; k++) begin
      if (stall_cnt[k] !== 32'(withheld[k])) report_value("stall_cnt_o", stall_cnt[k], withheld[k]);
    end
    @(posedge clk);
    #2;
    pulse_clear();
    @(negedge clk);
    for (int k = 0; k < N_TGT; k++) begin
      if (stall_cnt[k] !== '0) report_value("stall_cnt_o after clear", stall_cnt[k], 0);
    end
    @(posedge clk);
    #2;
    end_test(5, "stall counters", e0);

    e0 = errors;
    for (int h = 0; h < 3; h += 2) begin
      do_req(32'h50c0_0020, 1'b1, h);
      do_req(32'h50c0_0024, 1'b0, h);
      drain();
      do_req(32'h50e0_4020, 1'b1, h);
      drain();
      do_req(32'h50e0_4024, 1'b0, h);
      drain();
      do_req(32'h7000_0020, 1'b1, h);
      drain();
      do_req(32'h7000_0024, 1'b0, h);
      drain();
    end
    end_test(6, "perf strobes", e0);

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
logic/demux_bus_pkg.sv
logic/demux_map_pkg.sv
logic/addr_decode.sv
logic/target_port.sv
logic/return_mux.sv
logic/core_demux.sv
sim/core_demux_chk.sv
sim/core_demux_tb.sv

/* Makefile */
SIM  := obj_dir/Vcore_demux_tb
SRCS := $(wildcard logic/*.sv sim/*.sv)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module core_demux_tb -f vlog.f

clean:
	rm -rf obj_dir
